// File: filelist.f
+incdir+rtl
rtl/ps2_pkg.sv
rtl/disp_pkg.sv
rtl/ps2_rx.sv
rtl/ps2_fifo.sv
rtl/key_decoder.sv
rtl/key_display.sv
rtl/kbd_top.sv
dv/kbd_props.sv
dv/kbd_tb.sv

// File: Bender.yml
package:
  name: kbd_frontend

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ps2_pkg.sv
      - rtl/disp_pkg.sv
      - rtl/ps2_rx.sv
      - rtl/ps2_fifo.sv
      - rtl/key_decoder.sv
      - rtl/key_display.sv
      - rtl/kbd_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/kbd_props.sv
      - dv/kbd_tb.sv

// File: dv/kbd_tb.sv
/*
 * testbench for the keyboard front end: clock and reset, PS/2 frame
 * driver, stimulus table with expected digits, paused overflow burst
 */
`timescale 1ns/10ps
`include "ps2_cfg.svh"
`default_nettype none

module kbd_tb;
	import ps2_pkg::*;
	import disp_pkg::*;

	// frame to send and what the digits show afterwards
	typedef struct packed {
		logic [7:0] code;
		logic       par_ok;
		logic       pause;
		logic [7:0] exp_code;
		logic [7:0] exp_ascii;
		logic [7:0] exp_cnt;
	} row_t;

	logic        clk;
	logic        rst_n;
	logic        ps2_clk;
	logic        ps2_data;
	logic        pause;
	logic [7:0]  data;
	logic        ready;
	logic        overflow;
	seg_t        hex0, hex1, hex2, hex3, hex4, hex5;
	row_t        rows [0:31];
	int          n_rows;
	logic [31:0] seed;

	kbd_top uut (
		.clk(clk), .rst_n(rst_n), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.pause(pause), .data(data), .ready(ready), .overflow(overflow),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// active low, bit 0 = segment a
	function automatic logic [6:0] digit_pattern(input logic [3:0] n);
		logic [6:0] p;
		case (n)
			4'h0: p = 7'b1000000;
			4'h1: p = 7'b1111001;
			4'h2: p = 7'b0100100;
			4'h3: p = 7'b0110000;
			4'h4: p = 7'b0011001;
			4'h5: p = 7'b0010010;
			4'h6: p = 7'b0000010;
			4'h7: p = 7'b1111000;
			4'h8: p = 7'b0000000;
			4'h9: p = 7'b0010000;
			4'ha: p = 7'b0001000;
			4'hb: p = 7'b0000011;
			4'hc: p = 7'b1000110;
			4'hd: p = 7'b0100001;
			4'he: p = 7'b0000110;
			default: p = 7'b0001110;
		endcase
		return p;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// burst keys A to H as {make code, ascii}
	function automatic logic [15:0] filler_key(input logic [2:0] idx);
		logic [15:0] k;
		case (idx)
			3'd0: k = {8'h1c, 8'h41};
			3'd1: k = {8'h32, 8'h42};
			3'd2: k = {8'h21, 8'h43};
			3'd3: k = {8'h23, 8'h44};
			3'd4: k = {8'h24, 8'h45};
			3'd5: k = {8'h2b, 8'h46};
			3'd6: k = {8'h34, 8'h47};
			default: k = {8'h33, 8'h48};
		endcase
		return k;
	endfunction

	// failures seen by both bound checkers
	function automatic int assert_failures();
		return uut.u_fifo.u_fifo_props.fail_cnt + uut.u_dec.u_dec_props.fail_cnt;
	endfunction

	task automatic stop_fail(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
			stop_fail("a checked value did not match");
		end
	endtask

	task automatic check_digits(input logic [7:0] c, input logic [7:0] a,
			input logic [7:0] n, input string tag);
		check_val({hex1, hex0}, {digit_pattern(c[7:4]), digit_pattern(c[3:0])},
			{tag, " code digits"});
		check_val({hex3, hex2}, {digit_pattern(a[7:4]), digit_pattern(a[3:0])},
			{tag, " ascii digits"});
		check_val({hex5, hex4}, {digit_pattern(n[7:4]), digit_pattern(n[3:0])},
			{tag, " count digits"});
	endtask

	task automatic add_row(input logic [7:0] code, input logic par_ok, input logic pz,
			input logic [7:0] ec, input logic [7:0] ea, input logic [7:0] en);
		rows[n_rows] = {code, par_ok, pz, ec, ea, en};
		n_rows++;
	endtask

	// start, 8 data bits lsb first, odd parity, stop
	task automatic send_frame(input logic [7:0] code, input logic par_ok);
		logic [10:0] bits;
		bits = {1'b1, (~^code) ^ (~par_ok), code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clk);
			// data changes only while ps2_clk is high
			ps2_data <= bits[i];
			repeat (8) @(posedge clk);
			ps2_clk <= 1'b0;
			repeat (8) @(posedge clk);
			ps2_clk <= 1'b1;
		end
		@(posedge clk);
		ps2_data <= 1'b1;
	endtask

	task automatic wait_ready_low(input int max_cycles);
		int n;
		n = 0;
		while (ready && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (ready)
			stop_fail("timeout: ready stayed high, the decoder did not drain the buffer");
	endtask

	// stop at the first failing bound assertion
	always @(negedge clk) begin
		if (assert_failures() != 0)
			stop_fail("a bound assertion on the buffer or decoder failed");
	end

	initial begin
		logic [15:0] key;
		logic [7:0]  first_key;
		logic [7:0]  last_key;
		logic [7:0]  last_ascii;
		int          fill;
		logic        exp_ovf;
		rst_n    = 1'b0;
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
		pause    = 1'b0;
		n_rows   = 0;
		seed     = 32'hb6a8;
		fill     = 0;
		exp_ovf  = 1'b0;
		// presses of A, 5 and space
		add_row(8'h1c, 1'b1, 1'b0, 8'h1c, 8'h41, 8'd1);
		add_row(8'h2e, 1'b1, 1'b0, 8'h2e, 8'h35, 8'd2);
		add_row(8'h29, 1'b1, 1'b0, 8'h29, 8'h20, 8'd3);
		// release of A, then extended press and release, all absorbed
		add_row(BREAK_PREFIX, 1'b1, 1'b0, 8'h29, 8'h20, 8'd3);
		add_row(8'h1c, 1'b1, 1'b0, 8'h29, 8'h20, 8'd3);
		add_row(EXT_PREFIX, 1'b1, 1'b0, 8'h29, 8'h20, 8'd3);
		add_row(8'h75, 1'b1, 1'b0, 8'h29, 8'h20, 8'd3);
		add_row(EXT_PREFIX, 1'b1, 1'b0, 8'h29, 8'h20, 8'd3);
		add_row(BREAK_PREFIX, 1'b1, 1'b0, 8'h29, 8'h20, 8'd3);
		add_row(8'h75, 1'b1, 1'b0, 8'h29, 8'h20, 8'd3);
		// bad parity is dropped
		add_row(8'h3a, 1'b0, 1'b0, 8'h29, 8'h20, 8'd3);
		// unmapped code, then enter
		add_row(8'h05, 1'b1, 1'b0, 8'h05, 8'h00, 8'd4);
		add_row(8'h5a, 1'b1, 1'b0, 8'h5a, 8'h0d, 8'd5);
		// paused burst, one more than the buffer holds
		for (int i = 0; i <= `PS2_FIFO_DEPTH; i++) begin
			seed = lcg_next(seed);
			key  = filler_key(seed[18:16]);
			if (i == 0)
				first_key = key[15:8];
			if (i == `PS2_FIFO_DEPTH - 1) begin
				last_key   = key[15:8];
				last_ascii = key[7:0];
			end
			add_row(key[15:8], 1'b1, 1'b1, 8'h5a, 8'h0d, 8'd5);
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_val(ready, 1'b0, "ready after reset");
		check_val(overflow, 1'b0, "overflow after reset");
		check_digits(8'h00, 8'h00, 8'h00, "reset");
		for (int r = 0; r < n_rows; r++) begin
			@(posedge clk);
			pause <= rows[r].pause;
			send_frame(rows[r].code, rows[r].par_ok);
			// past receiver and buffer latency
			repeat (12) @(negedge clk);
			if (rows[r].pause) begin
				if (rows[r].par_ok)
					fill++;
				check_val(ready, 1'b1, "ready while paused");
				// first burst code stays at the head until released
				check_val(data, first_key, "oldest code while paused");
			end else
				wait_ready_low(200);
			repeat (3) @(negedge clk);
			exp_ovf = exp_ovf | (fill > `PS2_FIFO_DEPTH);
			check_val(overflow, exp_ovf, $sformatf("overflow, row %0d", r));
			check_digits(rows[r].exp_code, rows[r].exp_ascii, rows[r].exp_cnt,
				$sformatf("row %0d", r));
		end
		// drain the burst, ninth code was dropped
		@(posedge clk);
		pause <= 1'b0;
		@(negedge clk);
		wait_ready_low(200);
		repeat (3) @(negedge clk);
		check_digits(last_key, last_ascii, 8'(rows[n_rows-1].exp_cnt + `PS2_FIFO_DEPTH),
			"after release");
		check_val(overflow, 1'b1, "overflow after release");
		if (assert_failures() == 0) begin
			$display("sim passed");
			$finish;
		end else
			stop_fail("a bound assertion on the buffer or decoder failed");
	end

endmodule

`default_nettype wire

// File: dv/kbd_props.sv
/*
 * bound checks on the code buffer and key decoder:
 * pop only when ready, sticky overflow, press only after a pop
 */
`timescale 1ns/10ps
`default_nettype none

module kbd_props (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic ready,
	input wire logic nextdata_n,
	input wire logic overflow,
	input wire logic press_valid
);

	// count of failed assertions
	int fail_cnt = 0;

	// no pop request on an empty buffer
	a_pop_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!nextdata_n |-> ready)
		else begin
			fail_cnt++;
			$error("pop requested while buffer empty");
		end

	// once set, held until reset
	a_overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		overflow |=> overflow)
		else begin
			fail_cnt++;
			$error("overflow fell without reset");
		end

	// press event one cycle after its pop
	a_press_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
		press_valid |-> $past(!nextdata_n))
		else begin
			fail_cnt++;
			$error("press event without a preceding pop");
		end

endmodule

// buffer side has no press events, decoder side has no overflow
bind ps2_fifo kbd_props u_fifo_props (
	.clk(clk), .rst_n(rst_n), .ready(ready), .nextdata_n(nextdata_n),
	.overflow(overflow), .press_valid(1'b0)
);

bind key_decoder kbd_props u_dec_props (
	.clk(clk), .rst_n(rst_n), .ready(ready), .nextdata_n(nextdata_n),
	.overflow(1'b0), .press_valid(press_valid)
);

`default_nettype wire

// File: rtl/kbd_top.sv
/*
 * keyboard front end top level:
 * receiver, code buffer, key decoder, display stage
 */
`timescale 1ns/10ps
`default_nettype none

module kbd_top (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       ps2_clk,
	input  wire logic       ps2_data,
	input  wire logic       pause,
	output logic      [7:0] data,
	output logic            ready,
	output logic            overflow,
	output disp_pkg::seg_t  hex0,
	output disp_pkg::seg_t  hex1,
	output disp_pkg::seg_t  hex2,
	output disp_pkg::seg_t  hex3,
	output disp_pkg::seg_t  hex4,
	output disp_pkg::seg_t  hex5
);
	logic [7:0] code;
	logic       code_valid;
	logic       nextdata_n;
	logic       press_valid;
	logic [7:0] press_code;
	logic [7:0] press_ascii;

	// serial frames in, one code pulse per good frame
	ps2_rx u_rx (
		.clk        (clk),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.code       (code),
		.code_valid (code_valid)
	);

	ps2_fifo u_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.code       (code),
		.code_valid (code_valid),
		.nextdata_n (nextdata_n),
		.data       (data),
		.ready      (ready),
		.overflow   (overflow)
	);

	// pause holds off pops so the buffer fills
	key_decoder u_dec (
		.clk         (clk),
		.rst_n       (rst_n),
		.pause       (pause),
		.data        (data),
		.ready       (ready),
		.nextdata_n  (nextdata_n),
		.press_valid (press_valid),
		.press_code  (press_code),
		.press_ascii (press_ascii)
	);

	key_display u_disp (
		.clk         (clk),
		.rst_n       (rst_n),
		.press_valid (press_valid),
		.press_code  (press_code),
		.press_ascii (press_ascii),
		.hex0        (hex0),
		.hex1        (hex1),
		.hex2        (hex2),
		.hex3        (hex3),
		.hex4        (hex4),
		.hex5        (hex5)
	);

endmodule

`default_nettype wire

// File: rtl/key_display.sv
/*
 * display stage: last make code, its ASCII value and a wrapping
 * press count, shown as hex on six seven-segment digits
 */
`timescale 1ns/10ps
`include "ps2_cfg.svh"
`default_nettype none

module key_display (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       press_valid,
	input  wire logic [7:0] press_code,
	input  wire logic [7:0] press_ascii,
	output disp_pkg::seg_t  hex0,
	output disp_pkg::seg_t  hex1,
	output disp_pkg::seg_t  hex2,
	output disp_pkg::seg_t  hex3,
	output disp_pkg::seg_t  hex4,
	output disp_pkg::seg_t  hex5
);
	import disp_pkg::*;

	logic [7:0]              last_code;
	logic [7:0]              last_ascii;
	logic [`KEY_COUNT_W-1:0] press_cnt;

	// everything shows 00 until the first press
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_code  <= '0;
			last_ascii <= '0;
			press_cnt  <= '0;
		end else if (press_valid) begin
			last_code  <= press_code;
			last_ascii <= press_ascii;
			// wraps at 256
			press_cnt  <= press_cnt + 1'b1;
		end
	end

	// low nibble on the lower-numbered digit
	assign hex0 = hex_to_seg(last_code[3:0]);
	assign hex1 = hex_to_seg(last_code[7:4]);
	assign hex2 = hex_to_seg(last_ascii[3:0]);
	assign hex3 = hex_to_seg(last_ascii[7:4]);
	assign hex4 = hex_to_seg(press_cnt[3:0]);
	assign hex5 = hex_to_seg(press_cnt[7:4]);

endmodule

`default_nettype wire

// File: rtl/key_decoder.sv
/*
 * key decoder: pops codes from the buffer, absorbs break and
 * extended sequences, emits press events with an ASCII value
 */
`timescale 1ns/10ps
`default_nettype none

module key_decoder (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       pause,
	input  wire logic [7:0] data,
	input  wire logic       ready,
	output logic            nextdata_n,
	output logic            press_valid,
	output logic      [7:0] press_code,
	output logic      [7:0] press_ascii
);
	import ps2_pkg::*;

	dec_state_t state;
	logic       pop;
	logic       idle_q;
	logic       is_press;

	// set 2 make codes to ASCII, upper case only
	function automatic logic [7:0] to_ascii(input logic [7:0] sc);
		logic [7:0] a;
		case (sc)
			8'h1c: a = "A";
			8'h32: a = "B";
			8'h21: a = "C";
			8'h23: a = "D";
			8'h24: a = "E";
			8'h2b: a = "F";
			8'h34: a = "G";
			8'h33: a = "H";
			8'h43: a = "I";
			8'h3b: a = "J";
			8'h42: a = "K";
			8'h4b: a = "L";
			8'h3a: a = "M";
			8'h31: a = "N";
			8'h44: a = "O";
			8'h4d: a = "P";
			8'h15: a = "Q";
			8'h2d: a = "R";
			8'h1b: a = "S";
			8'h2c: a = "T";
			8'h3c: a = "U";
			8'h2a: a = "V";
			8'h1d: a = "W";
			8'h22: a = "X";
			8'h35: a = "Y";
			8'h1a: a = "Z";
			8'h45: a = "0";
			8'h16: a = "1";
			8'h1e: a = "2";
			8'h26: a = "3";
			8'h25: a = "4";
			8'h2e: a = "5";
			8'h36: a = "6";
			8'h3d: a = "7";
			8'h3e: a = "8";
			8'h46: a = "9";
			8'h29: a = 8'h20;
			// enter
			8'h5a: a = 8'h0d;
			default: a = 8'h00;
		endcase
		return a;
	endfunction

	// one pop, then one idle cycle while data advances
	assign pop        = ready & ~pause & ~idle_q;
	assign nextdata_n = ~pop;
	assign is_press   = (state == NORMAL) &&
	                    (data != BREAK_PREFIX) && (data != EXT_PREFIX);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= NORMAL;
			idle_q      <= 1'b0;
			press_valid <= 1'b0;
		end else begin
			idle_q      <= pop;
			press_valid <= pop & is_press;
			if (pop) begin
				case (data)
					BREAK_PREFIX: state <= BREAK;
					// E0 inside a break sequence keeps waiting for the key
					EXT_PREFIX:   state <= (state == BREAK) ? BREAK : EXTENDED;
					// released or extended key consumed here
					default:      state <= NORMAL;
				endcase
			end
		end
	end

	// payload, qualified by press_valid downstream
	always_ff @(posedge clk) begin
		if (pop) begin
			press_code  <= data;
			press_ascii <= to_ascii(data);
		end
	end

endmodule

`default_nettype wire

// File: rtl/ps2_fifo.sv
/*
 * circular buffer of received scancodes, oldest code on data,
 * ready while not empty, pop on nextdata_n low, sticky overflow
 */
`timescale 1ns/10ps
`include "ps2_cfg.svh"
`default_nettype none

module ps2_fifo (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic [7:0] code,
	input  wire logic       code_valid,
	input  wire logic       nextdata_n,
	output logic      [7:0] data,
	output logic            ready,
	output logic            overflow
);
	localparam int DEPTH = `PS2_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = PTR_W + 1;

	logic [7:0]       mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             push;
	logic             pop;

	// wrap explicitly, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full  = (count == CNT_W'(DEPTH));
	assign ready = (count != '0);
	assign push  = code_valid & ~full;
	// pop on empty is ignored
	assign pop   = ~nextdata_n & ready;
	assign data  = mem[rd_ptr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// simultaneous push and pop leaves count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// only reset clears it
			if (code_valid && full)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= code;
	end

endmodule

`default_nettype wire

// File: rtl/ps2_rx.sv
/*
 * PS/2 serial frame receiver: line synchronizers, falling edge detect,
 * 11-bit frame FSM with odd parity and stop bit checks
 */
`timescale 1ns/10ps
`include "ps2_cfg.svh"
`default_nettype none

module ps2_rx (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       ps2_clk,
	input  wire logic       ps2_data,
	output logic      [7:0] code,
	output logic            code_valid
);
	import ps2_pkg::*;

	localparam int SYNC_N = `PS2_SYNC_STAGES;

	logic [SYNC_N-1:0] clk_sync;
	logic [SYNC_N-1:0] data_sync;
	logic              clk_prev;
	logic              clk_s;
	logic              data_s;
	logic              fall;
	rx_state_t         state;
	logic        [2:0] bit_cnt;
	logic        [7:0] shift_q;
	logic              parity_ok;

	assign clk_s  = clk_sync[SYNC_N-1];
	assign data_s = data_sync[SYNC_N-1];
	// keyboard drives data while its clock is low
	assign fall   = clk_prev & ~clk_s;

	// both lines idle high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[SYNC_N-2:0], ps2_clk};
			data_sync <= {data_sync[SYNC_N-2:0], ps2_data};
			clk_prev  <= clk_s;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			bit_cnt    <= '0;
			parity_ok  <= 1'b0;
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (fall) begin
				case (state)
					IDLE: begin
						// start bit must be 0
						if (!data_s) begin
							state   <= DATA;
							bit_cnt <= '0;
						end
					end
					DATA: begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= PARITY;
					end
					PARITY: begin
						// odd parity over data plus parity bit
						parity_ok <= ^{shift_q, data_s};
						state     <= STOP;
					end
					default: begin
						// bad frame just falls back to idle
						code_valid <= data_s & parity_ok;
						state      <= IDLE;
					end
				endcase
			end
		end
	end

	// lsb first, so shift in from the top
	always_ff @(posedge clk) begin
		if (fall && state == DATA)
			shift_q <= {data_s, shift_q[7:1]};
	end

	// stable until the next frame's first data bit
	assign code = shift_q;

endmodule

`default_nettype wire

// File: rtl/disp_pkg.sv
/*
 * seven-segment display types: active-low pattern type
 * and the hex digit to pattern function
 */
`default_nettype none

package disp_pkg;

	// active low, bit 0 is segment a, bit 6 is segment g
	typedef logic [6:0] seg_t;

	function automatic seg_t hex_to_seg(input logic [3:0] digit);
		seg_t seg;
		case (digit)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h10;
			4'ha: seg = 7'h08;
			// lower-case b and d so they differ from 8 and 0
			4'hb: seg = 7'h03;
			4'hc: seg = 7'h46;
			4'hd: seg = 7'h21;
			4'he: seg = 7'h06;
			default: seg = 7'h0e;
		endcase
		return seg;
	endfunction

endpackage

`default_nettype wire

// File: rtl/ps2_pkg.sv
/*
 * PS/2 side types: receiver FSM states, decoder FSM states,
 * and the scancode prefix bytes
 */
`default_nettype none

package ps2_pkg;

	// serial frame receiver
	typedef enum logic [1:0] {
		IDLE,
		DATA,
		PARITY,
		STOP
	} rx_state_t;

	// prefix tracking in the key decoder
	typedef enum logic [1:0] {
		NORMAL,
		BREAK,
		EXTENDED
	} dec_state_t;

	// set 2 prefix bytes
	typedef enum logic [7:0] {
		BREAK_PREFIX = 8'hf0,
		EXT_PREFIX   = 8'he0
	} scan_op_t;

endpackage

`default_nettype wire

// File: rtl/ps2_cfg.svh
/*
 * build-time sizes for the keyboard front end:
 * code buffer depth, synchronizer depth, press counter width
 */
`ifndef PS2_CFG_SVH
`define PS2_CFG_SVH

`default_nettype none

// codes held between receiver and decoder
`define PS2_FIFO_DEPTH 8

// flops on ps2_clk and ps2_data before use
`define PS2_SYNC_STAGES 2

// press counter, shown on two digits
`define KEY_COUNT_W 8

`default_nettype wire

`endif
